// File: rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// slots per cycle, one bank per slot
`define ROB_DISPATCH_WIDTH 2
`define ROB_BANK_BITS 1

// rows per bank
`define ROB_ROWS 8
`define ROB_ROW_BITS 3

`define ROB_ENTRIES (`ROB_ROWS * `ROB_DISPATCH_WIDTH)
`define ROB_PTR_BITS (`ROB_ROW_BITS + `ROB_BANK_BITS)
`define ROB_CNT_BITS (`ROB_PTR_BITS + 1)
`define ROB_RETIRE_BITS 2

// physical register file
`define ROB_PHYS_REGS 64
`define ROB_PHYS_BITS 6

`define ROB_ARCH_BITS 5
`define ROB_XLEN 32

`endif

// File: rob_pkg.sv
package rob_pkg;

  // per entry lifecycle
  typedef enum logic [1:0] {
    ST_EMPTY   = 2'd0,
    ST_PENDING = 2'd1,
    ST_DONE    = 2'd2
  } rob_entry_state_e;

endpackage

// File: rob_alloc.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_alloc (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         dispatch_en        [0:`ROB_DISPATCH_WIDTH-1],
  input  logic                         flush,
  input  logic [`ROB_RETIRE_BITS-1:0]  retire_count,
  output logic [`ROB_BANK_BITS-1:0]    dispatch_bank_addr [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_ROW_BITS-1:0]     dispatch_rob_addr  [0:`ROB_DISPATCH_WIDTH-1],
  output logic                         dispatch_full,
  output logic                         bank_we            [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_ROW_BITS-1:0]     bank_row           [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_BANK_BITS-1:0]    bank_slot_sel      [0:`ROB_DISPATCH_WIDTH-1]
);

  localparam logic [`ROB_CNT_BITS-1:0] FULL_LEVEL = `ROB_ENTRIES - `ROB_DISPATCH_WIDTH;

  logic [`ROB_PTR_BITS-1:0]    tail;
  logic [`ROB_CNT_BITS-1:0]    count;
  logic [`ROB_PTR_BITS-1:0]    alloc_pos;
  logic [`ROB_RETIRE_BITS-1:0] n_alloc;
  logic                        accept;

  // fewer than two free entries
  assign dispatch_full = count > FULL_LEVEL;
  assign accept = !dispatch_full && !flush;

  // compact enabled slots onto consecutive positions from the tail
  always_comb begin
    alloc_pos = tail;
    n_alloc = '0;
    for (int b = 0; b < `ROB_DISPATCH_WIDTH; b++) begin
      bank_we[b] = 1'b0;
      bank_row[b] = '0;
      bank_slot_sel[b] = '0;
    end
    for (int s = 0; s < `ROB_DISPATCH_WIDTH; s++) begin
      dispatch_bank_addr[s] = alloc_pos[`ROB_BANK_BITS-1:0];
      dispatch_rob_addr[s] = alloc_pos[`ROB_PTR_BITS-1:`ROB_BANK_BITS];
      if (dispatch_en[s]) begin
        if (accept) begin
          bank_we[alloc_pos[`ROB_BANK_BITS-1:0]] = 1'b1;
          bank_row[alloc_pos[`ROB_BANK_BITS-1:0]] = alloc_pos[`ROB_PTR_BITS-1:`ROB_BANK_BITS];
          bank_slot_sel[alloc_pos[`ROB_BANK_BITS-1:0]] = `ROB_BANK_BITS'(s);
          n_alloc = n_alloc + 1'b1;
        end
        alloc_pos = alloc_pos + 1'b1;
      end
    end
  end

  // tail and occupancy, both cleared by a mispredict flush
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      tail <= '0;
      count <= '0;
    end else begin
      tail <= tail + `ROB_PTR_BITS'(n_alloc);
      count <= count + `ROB_CNT_BITS'(n_alloc) - `ROB_CNT_BITS'(retire_count);
    end
  end

endmodule

// File: rob_bank.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_bank import rob_pkg::*; #(
  parameter int unsigned BANK_IDX = 0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        flush,
  // dispatch write
  input  logic                        we,
  input  logic [`ROB_ROW_BITS-1:0]    row,
  input  logic [`ROB_PHYS_BITS-1:0]   phys_rd,
  input  logic [`ROB_ARCH_BITS-1:0]   arch_rd,
  input  logic                        is_branch,
  input  logic [`ROB_XLEN-1:0]        pc,
  input  logic [`ROB_XLEN-1:0]        instr,
  // writeback, all slots seen by every bank
  input  logic                        wb_en             [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_ROW_BITS-1:0]    wb_row            [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_BANK_BITS-1:0]   wb_sel_bank       [0:`ROB_DISPATCH_WIDTH-1],
  input  logic                        wb_branch_correct [0:`ROB_DISPATCH_WIDTH-1],
  // head read and free
  input  logic [`ROB_ROW_BITS-1:0]    head_row,
  input  logic                        free,
  output rob_entry_state_e            head_state,
  output logic [`ROB_PHYS_BITS-1:0]   head_phys_rd,
  output logic [`ROB_ARCH_BITS-1:0]   head_arch_rd,
  output logic [`ROB_XLEN-1:0]        head_pc,
  output logic [`ROB_XLEN-1:0]        head_instr,
  output logic                        head_mispredict
);

  rob_entry_state_e            state        [0:`ROB_ROWS-1];
  logic [`ROB_PHYS_BITS-1:0]   phys_rd_q    [0:`ROB_ROWS-1];
  logic [`ROB_ARCH_BITS-1:0]   arch_rd_q    [0:`ROB_ROWS-1];
  logic [`ROB_XLEN-1:0]        pc_q         [0:`ROB_ROWS-1];
  logic [`ROB_XLEN-1:0]        instr_q      [0:`ROB_ROWS-1];
  logic                        is_branch_q  [0:`ROB_ROWS-1];
  logic                        mispredict_q [0:`ROB_ROWS-1];
  logic                        wb_hit       [0:`ROB_DISPATCH_WIDTH-1];

  // writebacks aimed at this bank and a live entry
  always_comb begin
    for (int i = 0; i < `ROB_DISPATCH_WIDTH; i++) begin
      wb_hit[i] = wb_en[i] && (wb_sel_bank[i] == BANK_IDX) && (state[wb_row[i]] != ST_EMPTY);
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      for (int r = 0; r < `ROB_ROWS; r++) begin
        state[r] <= ST_EMPTY;
      end
    end else begin
      for (int i = 0; i < `ROB_DISPATCH_WIDTH; i++) begin
        if (wb_hit[i]) begin
          state[wb_row[i]] <= ST_DONE;
        end
      end
      // commit frees the head row
      if (free) begin
        state[head_row] <= ST_EMPTY;
      end
      if (we) begin
        state[row] <= ST_PENDING;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `ROB_DISPATCH_WIDTH; i++) begin
      if (wb_hit[i]) begin
        mispredict_q[wb_row[i]] <= is_branch_q[wb_row[i]] && !wb_branch_correct[i];
      end
    end
    if (we) begin
      phys_rd_q[row] <= phys_rd;
      arch_rd_q[row] <= arch_rd;
      pc_q[row] <= pc;
      instr_q[row] <= instr;
      is_branch_q[row] <= is_branch;
      mispredict_q[row] <= 1'b0;
    end
  end

  assign head_state = state[head_row];
  assign head_phys_rd = phys_rd_q[head_row];
  assign head_arch_rd = arch_rd_q[head_row];
  assign head_pc = pc_q[head_row];
  assign head_instr = instr_q[head_row];
  assign head_mispredict = mispredict_q[head_row];

endmodule

// File: rob_retire.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_retire import rob_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  // bank heads
  input  rob_entry_state_e             head_state      [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_PHYS_BITS-1:0]    head_phys_rd    [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_ARCH_BITS-1:0]    head_arch_rd    [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_XLEN-1:0]         head_pc         [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_XLEN-1:0]         head_instr      [0:`ROB_DISPATCH_WIDTH-1],
  input  logic                         head_mispredict [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_ROW_BITS-1:0]     head_row        [0:`ROB_DISPATCH_WIDTH-1],
  output logic                         free            [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_RETIRE_BITS-1:0]  retire_count,
  output logic                         flush,
  // commit slots in program order
  output logic                         commit_en       [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_PHYS_BITS-1:0]    commit_phys_rd  [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_ARCH_BITS-1:0]    commit_arch_rd  [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_XLEN-1:0]         commit_pc       [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_XLEN-1:0]         commit_instr    [0:`ROB_DISPATCH_WIDTH-1]
);

  logic [`ROB_PTR_BITS-1:0]  head;
  logic [`ROB_PTR_BITS-1:0]  slot_pos  [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_BANK_BITS-1:0] slot_bank [0:`ROB_DISPATCH_WIDTH-1];
  logic                      in_order;

  // oldest entries: head, head+1, each in its own bank
  always_comb begin
    for (int b = 0; b < `ROB_DISPATCH_WIDTH; b++) begin
      head_row[b] = '0;
    end
    for (int s = 0; s < `ROB_DISPATCH_WIDTH; s++) begin
      slot_pos[s] = head + `ROB_PTR_BITS'(s);
      slot_bank[s] = slot_pos[s][`ROB_BANK_BITS-1:0];
      head_row[slot_bank[s]] = slot_pos[s][`ROB_PTR_BITS-1:`ROB_BANK_BITS];
    end
  end

  // commit done entries in order, stop after a mispredicted branch
  always_comb begin
    in_order = 1'b1;
    flush = 1'b0;
    retire_count = '0;
    for (int b = 0; b < `ROB_DISPATCH_WIDTH; b++) begin
      free[b] = 1'b0;
    end
    for (int s = 0; s < `ROB_DISPATCH_WIDTH; s++) begin
      commit_en[s] = in_order && (head_state[slot_bank[s]] == ST_DONE);
      free[slot_bank[s]] = commit_en[s];
      commit_phys_rd[s] = head_phys_rd[slot_bank[s]];
      commit_arch_rd[s] = head_arch_rd[slot_bank[s]];
      commit_pc[s] = head_pc[slot_bank[s]];
      commit_instr[s] = head_instr[slot_bank[s]];
      if (commit_en[s]) begin
        retire_count = retire_count + 1'b1;
        if (head_mispredict[slot_bank[s]]) begin
          flush = 1'b1;
        end
      end
      in_order = commit_en[s] && !head_mispredict[slot_bank[s]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head <= '0;
    end else begin
      head <= head + `ROB_PTR_BITS'(retire_count);
    end
  end

endmodule

// File: rob_ready_table.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_ready_table (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        dispatch_en        [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_PHYS_BITS-1:0]   dispatch_phys_rd   [0:`ROB_DISPATCH_WIDTH-1],
  input  logic                        wb_en              [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_PHYS_BITS-1:0]   wb_phys_rd         [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_PHYS_BITS-1:0]   op_fetch_phys_rs1  [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_PHYS_BITS-1:0]   op_fetch_phys_rs2  [0:`ROB_DISPATCH_WIDTH-1],
  output logic                        op_fetch_rs1_valid [0:`ROB_DISPATCH_WIDTH-1],
  output logic                        op_fetch_rs2_valid [0:`ROB_DISPATCH_WIDTH-1]
);

  logic [`ROB_PHYS_REGS-1:0] ready;

  // a new producer wins over an older writeback to the same register
  always_ff @(posedge clk) begin
    if (rst) begin
      ready <= '1;
    end else begin
      for (int i = 0; i < `ROB_DISPATCH_WIDTH; i++) begin
        if (wb_en[i]) begin
          ready[wb_phys_rd[i]] <= 1'b1;
        end
      end
      for (int i = 0; i < `ROB_DISPATCH_WIDTH; i++) begin
        if (dispatch_en[i]) begin
          ready[dispatch_phys_rd[i]] <= 1'b0;
        end
      end
    end
  end

  // writeback this cycle bypasses to the read
  always_comb begin
    for (int p = 0; p < `ROB_DISPATCH_WIDTH; p++) begin
      op_fetch_rs1_valid[p] = ready[op_fetch_phys_rs1[p]];
      op_fetch_rs2_valid[p] = ready[op_fetch_phys_rs2[p]];
      for (int w = 0; w < `ROB_DISPATCH_WIDTH; w++) begin
        if (wb_en[w] && wb_phys_rd[w] == op_fetch_phys_rs1[p]) begin
          op_fetch_rs1_valid[p] = 1'b1;
        end
        if (wb_en[w] && wb_phys_rd[w] == op_fetch_phys_rs2[p]) begin
          op_fetch_rs2_valid[p] = 1'b1;
        end
      end
    end
  end

endmodule

// File: rob_top.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_top import rob_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  // dispatch
  input  logic                        dispatch_en              [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_PHYS_BITS-1:0]   dispatch_phys_rd         [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_ARCH_BITS-1:0]   dispatch_arch_rd         [0:`ROB_DISPATCH_WIDTH-1],
  input  logic                        dispatch_is_branch       [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_XLEN-1:0]        dispatch_pc              [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_XLEN-1:0]        dispatch_instr           [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_BANK_BITS-1:0]   dispatch_bank_addr       [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_ROW_BITS-1:0]    dispatch_rob_addr        [0:`ROB_DISPATCH_WIDTH-1],
  output logic                        dispatch_full,
  // writeback
  input  logic                        writeback_en             [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_BANK_BITS-1:0]   writeback_bank_addr      [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_ROW_BITS-1:0]    writeback_rob_addr       [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_PHYS_BITS-1:0]   writeback_phys_rd        [0:`ROB_DISPATCH_WIDTH-1],
  input  logic                        writeback_is_branch      [0:`ROB_DISPATCH_WIDTH-1],
  input  logic                        writeback_branch_correct [0:`ROB_DISPATCH_WIDTH-1],
  // commit
  output logic                        commit_en                [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_PHYS_BITS-1:0]   commit_phys_rd           [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_ARCH_BITS-1:0]   commit_arch_rd           [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_XLEN-1:0]        commit_pc                [0:`ROB_DISPATCH_WIDTH-1],
  output logic [`ROB_XLEN-1:0]        commit_instr             [0:`ROB_DISPATCH_WIDTH-1],
  output logic                        flush,
  // operand fetch
  input  logic [`ROB_PHYS_BITS-1:0]   op_fetch_phys_rs1        [0:`ROB_DISPATCH_WIDTH-1],
  input  logic [`ROB_PHYS_BITS-1:0]   op_fetch_phys_rs2        [0:`ROB_DISPATCH_WIDTH-1],
  output logic                        op_fetch_rs1_valid       [0:`ROB_DISPATCH_WIDTH-1],
  output logic                        op_fetch_rs2_valid       [0:`ROB_DISPATCH_WIDTH-1]
);

  logic                        bank_we         [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_ROW_BITS-1:0]    bank_row        [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_BANK_BITS-1:0]   bank_slot_sel   [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_PHYS_BITS-1:0]   bank_phys_rd    [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_ARCH_BITS-1:0]   bank_arch_rd    [0:`ROB_DISPATCH_WIDTH-1];
  logic                        bank_is_branch  [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_XLEN-1:0]        bank_pc         [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_XLEN-1:0]        bank_instr      [0:`ROB_DISPATCH_WIDTH-1];
  logic                        wb_correct      [0:`ROB_DISPATCH_WIDTH-1];
  rob_entry_state_e            head_state      [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_PHYS_BITS-1:0]   head_phys_rd    [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_ARCH_BITS-1:0]   head_arch_rd    [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_XLEN-1:0]        head_pc         [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_XLEN-1:0]        head_instr      [0:`ROB_DISPATCH_WIDTH-1];
  logic                        head_mispredict [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_ROW_BITS-1:0]    head_row        [0:`ROB_DISPATCH_WIDTH-1];
  logic                        free            [0:`ROB_DISPATCH_WIDTH-1];
  logic [`ROB_RETIRE_BITS-1:0] retire_count;

  // route dispatch slots to banks, non-branches always resolve correct
  always_comb begin
    for (int b = 0; b < `ROB_DISPATCH_WIDTH; b++) begin
      bank_phys_rd[b] = dispatch_phys_rd[bank_slot_sel[b]];
      bank_arch_rd[b] = dispatch_arch_rd[bank_slot_sel[b]];
      bank_is_branch[b] = dispatch_is_branch[bank_slot_sel[b]];
      bank_pc[b] = dispatch_pc[bank_slot_sel[b]];
      bank_instr[b] = dispatch_instr[bank_slot_sel[b]];
      wb_correct[b] = writeback_branch_correct[b] || !writeback_is_branch[b];
    end
  end

  rob_alloc alloc0 (
    .clk, .rst, .dispatch_en, .flush, .retire_count,
    .dispatch_bank_addr, .dispatch_rob_addr, .dispatch_full,
    .bank_we, .bank_row, .bank_slot_sel
  );

  for (genvar b = 0; b < `ROB_DISPATCH_WIDTH; b++) begin : g_bank
    rob_bank #(.BANK_IDX(b)) bank0 (
      .clk, .rst, .flush,
      .we(bank_we[b]), .row(bank_row[b]), .phys_rd(bank_phys_rd[b]),
      .arch_rd(bank_arch_rd[b]), .is_branch(bank_is_branch[b]),
      .pc(bank_pc[b]), .instr(bank_instr[b]),
      .wb_en(writeback_en), .wb_row(writeback_rob_addr),
      .wb_sel_bank(writeback_bank_addr), .wb_branch_correct(wb_correct),
      .head_row(head_row[b]), .free(free[b]),
      .head_state(head_state[b]), .head_phys_rd(head_phys_rd[b]),
      .head_arch_rd(head_arch_rd[b]), .head_pc(head_pc[b]),
      .head_instr(head_instr[b]), .head_mispredict(head_mispredict[b])
    );
  end

  rob_retire retire0 (
    .clk, .rst, .head_state, .head_phys_rd, .head_arch_rd, .head_pc, .head_instr,
    .head_mispredict, .head_row, .free, .retire_count, .flush,
    .commit_en, .commit_phys_rd, .commit_arch_rd, .commit_pc, .commit_instr
  );

  rob_ready_table ready0 (
    .clk, .rst,
    .dispatch_en(bank_we), .dispatch_phys_rd(bank_phys_rd),
    .wb_en(writeback_en), .wb_phys_rd(writeback_phys_rd),
    .op_fetch_phys_rs1, .op_fetch_phys_rs2,
    .op_fetch_rs1_valid, .op_fetch_rs2_valid
  );

endmodule

// File: rob_asserts.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_asserts (
  input logic clk,
  input logic rst,
  input logic commit_en [0:`ROB_DISPATCH_WIDTH-1],
  input logic flush,
  input logic dispatch_full
);

  int fail_count = 0;

  // second slot only commits behind the first
  commit_in_order: assert property (
    @(posedge clk) disable iff (rst) commit_en[1] |-> commit_en[0]
  ) else begin
    fail_count++;
    $error("commit slot 1 active without slot 0");
  end

  // flush is a single cycle pulse
  flush_single: assert property (
    @(posedge clk) disable iff (rst) flush |=> !flush
  ) else begin
    fail_count++;
    $error("flush high for two cycles");
  end

  // buffer is empty after a flush
  empty_after_flush: assert property (
    @(posedge clk) disable iff (rst) flush |=> !dispatch_full
  ) else begin
    fail_count++;
    $error("dispatch_full high after flush");
  end

endmodule

bind rob_top rob_asserts asserts0 (
  .clk, .rst, .commit_en, .flush, .dispatch_full
);

// File: tb_rob.sv
`timescale 1ns/1ps
`include "rob_settings.svh"

module tb_rob;

  localparam int W = `ROB_DISPATCH_WIDTH;

  typedef struct {
    logic [`ROB_XLEN-1:0]      pc;
    logic [`ROB_XLEN-1:0]      instr;
    logic [`ROB_ARCH_BITS-1:0] arch_rd;
    logic [`ROB_PHYS_BITS-1:0] phys_rd;
    logic                      is_branch;
    logic [`ROB_BANK_BITS-1:0] bank;
    logic [`ROB_ROW_BITS-1:0]  row;
    logic                      done;
    logic                      mispredict;
  } entry_t;

  logic clk;
  logic rst;
  logic                      dispatch_en [0:W-1];
  logic [`ROB_PHYS_BITS-1:0] dispatch_phys_rd [0:W-1];
  logic [`ROB_ARCH_BITS-1:0] dispatch_arch_rd [0:W-1];
  logic                      dispatch_is_branch [0:W-1];
  logic [`ROB_XLEN-1:0]      dispatch_pc [0:W-1];
  logic [`ROB_XLEN-1:0]      dispatch_instr [0:W-1];
  logic [`ROB_BANK_BITS-1:0] dispatch_bank_addr [0:W-1];
  logic [`ROB_ROW_BITS-1:0]  dispatch_rob_addr [0:W-1];
  logic                      dispatch_full;
  logic                      writeback_en [0:W-1];
  logic [`ROB_BANK_BITS-1:0] writeback_bank_addr [0:W-1];
  logic [`ROB_ROW_BITS-1:0]  writeback_rob_addr [0:W-1];
  logic [`ROB_PHYS_BITS-1:0] writeback_phys_rd [0:W-1];
  logic                      writeback_is_branch [0:W-1];
  logic                      writeback_branch_correct [0:W-1];
  logic                      commit_en [0:W-1];
  logic [`ROB_PHYS_BITS-1:0] commit_phys_rd [0:W-1];
  logic [`ROB_ARCH_BITS-1:0] commit_arch_rd [0:W-1];
  logic [`ROB_XLEN-1:0]      commit_pc [0:W-1];
  logic [`ROB_XLEN-1:0]      commit_instr [0:W-1];
  logic                      flush;
  logic [`ROB_PHYS_BITS-1:0] op_fetch_phys_rs1 [0:W-1];
  logic [`ROB_PHYS_BITS-1:0] op_fetch_phys_rs2 [0:W-1];
  logic                      op_fetch_rs1_valid [0:W-1];
  logic                      op_fetch_rs2_valid [0:W-1];

  // program order model
  entry_t                   model_q [$];
  logic                     ready_model [0:`ROB_PHYS_REGS-1];
  logic [`ROB_PTR_BITS-1:0] tail;
  int                       wb_idx [0:W-1];
  int unsigned              lcg_state = 27;
  logic [`ROB_XLEN-1:0]     pc_next;
  int                       flush_count;

  rob_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #10;
      clk = ~clk;
    end
  end

  function automatic int unsigned rand_below(int unsigned range);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % range;
  endfunction

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %0h actual %0h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic fail_timeout(string what);
    $display("ERROR timeout, %s", what);
    $display("Test failed");
    $fatal(1, "timeout");
  endtask

  task automatic idle_inputs();
    for (int s = 0; s < W; s++) begin
      dispatch_en[s] = 1'b0;
      dispatch_phys_rd[s] = '0;
      dispatch_arch_rd[s] = '0;
      dispatch_is_branch[s] = 1'b0;
      dispatch_pc[s] = '0;
      dispatch_instr[s] = '0;
      writeback_en[s] = 1'b0;
      writeback_bank_addr[s] = '0;
      writeback_rob_addr[s] = '0;
      writeback_phys_rd[s] = '0;
      writeback_is_branch[s] = 1'b0;
      writeback_branch_correct[s] = 1'b0;
      op_fetch_phys_rs1[s] = '0;
      op_fetch_phys_rs2[s] = '0;
      wb_idx[s] = -1;
    end
  endtask

  // check at the falling edge and step the model past the next rising edge
  task automatic check_and_step();
    logic [`ROB_PTR_BITS-1:0] pos;
    logic                     exp_rs1;
    logic                     exp_rs2;
    logic                     exp_en;
    bit                       exp_flush;
    int                       n_commit;
    entry_t                   e;
    pos = tail;
    for (int s = 0; s < W; s++) begin
      if (dispatch_en[s]) begin
        check_value("dispatch_bank", pos[`ROB_BANK_BITS-1:0], dispatch_bank_addr[s]);
        check_value("dispatch_row", pos[`ROB_PTR_BITS-1:`ROB_BANK_BITS], dispatch_rob_addr[s]);
        pos = pos + 1'b1;
      end
    end
    for (int p = 0; p < W; p++) begin
      exp_rs1 = ready_model[op_fetch_phys_rs1[p]];
      exp_rs2 = ready_model[op_fetch_phys_rs2[p]];
      for (int w = 0; w < W; w++) begin
        if (writeback_en[w] && writeback_phys_rd[w] == op_fetch_phys_rs1[p]) exp_rs1 = 1'b1;
        if (writeback_en[w] && writeback_phys_rd[w] == op_fetch_phys_rs2[p]) exp_rs2 = 1'b1;
      end
      check_value("rs1_valid", exp_rs1, op_fetch_rs1_valid[p]);
      check_value("rs2_valid", exp_rs2, op_fetch_rs2_valid[p]);
    end
    n_commit = 0;
    exp_flush = 1'b0;
    for (int s = 0; s < W; s++) begin
      exp_en = !exp_flush && n_commit == s && model_q.size() > s && model_q[s].done;
      check_value("commit_en", exp_en, commit_en[s]);
      if (exp_en) begin
        check_value("commit_pc", model_q[s].pc, commit_pc[s]);
        check_value("commit_instr", model_q[s].instr, commit_instr[s]);
        check_value("commit_arch_rd", model_q[s].arch_rd, commit_arch_rd[s]);
        check_value("commit_phys_rd", model_q[s].phys_rd, commit_phys_rd[s]);
        n_commit++;
        exp_flush = model_q[s].mispredict;
      end
    end
    check_value("flush", exp_flush, flush);
    check_value("dispatch_full", model_q.size() > `ROB_ENTRIES - W, dispatch_full);
    // writeback lands before a new producer clears its register
    for (int w = 0; w < W; w++) begin
      if (writeback_en[w]) begin
        model_q[wb_idx[w]].done = 1'b1;
        model_q[wb_idx[w]].mispredict = writeback_is_branch[w] && !writeback_branch_correct[w];
        ready_model[writeback_phys_rd[w]] = 1'b1;
      end
    end
    repeat (n_commit) void'(model_q.pop_front());
    if (exp_flush) begin
      model_q.delete();
      tail = '0;
      flush_count++;
    end else begin
      for (int s = 0; s < W; s++) begin
        if (dispatch_en[s]) begin
          e.pc = dispatch_pc[s];
          e.instr = dispatch_instr[s];
          e.arch_rd = dispatch_arch_rd[s];
          e.phys_rd = dispatch_phys_rd[s];
          e.is_branch = dispatch_is_branch[s];
          e.bank = dispatch_bank_addr[s];
          e.row = dispatch_rob_addr[s];
          e.done = 1'b0;
          e.mispredict = 1'b0;
          model_q.push_back(e);
          ready_model[dispatch_phys_rd[s]] = 1'b0;
          tail = tail + 1'b1;
        end
      end
    end
  endtask

  task automatic run_cycle(bit dispatch_on, bit wb_on);
    int pick;
    @(posedge clk);
    #2;
    idle_inputs();
    for (int s = 0; s < W; s++) begin
      dispatch_en[s] = dispatch_on && model_q.size() <= `ROB_ENTRIES - W && rand_below(4) != 0;
      dispatch_phys_rd[s] = `ROB_PHYS_BITS'(rand_below(`ROB_PHYS_REGS));
      dispatch_arch_rd[s] = `ROB_ARCH_BITS'(rand_below(32));
      dispatch_is_branch[s] = rand_below(6) == 0;
      dispatch_pc[s] = pc_next;
      dispatch_instr[s] = {16'(rand_below(65536)), 16'(rand_below(65536))};
      pc_next = pc_next + 4;
      op_fetch_phys_rs1[s] = `ROB_PHYS_BITS'(rand_below(`ROB_PHYS_REGS));
      op_fetch_phys_rs2[s] = `ROB_PHYS_BITS'(rand_below(`ROB_PHYS_REGS));
      if (wb_on && model_q.size() != 0 && rand_below(3) != 0) begin
        pick = int'(rand_below(model_q.size()));
        if (!model_q[pick].done && (s == 0 || pick != wb_idx[0])) begin
          wb_idx[s] = pick;
          writeback_en[s] = 1'b1;
          writeback_bank_addr[s] = model_q[pick].bank;
          writeback_rob_addr[s] = model_q[pick].row;
          writeback_phys_rd[s] = model_q[pick].phys_rd;
          writeback_is_branch[s] = model_q[pick].is_branch;
          writeback_branch_correct[s] = rand_below(4) != 0;
        end
      end
    end
    #8;
    check_and_step();
  endtask

  initial begin
    int guard;
    rst = 1'b1;
    idle_inputs();
    tail = '0;
    pc_next = 32'h0000_1000;
    flush_count = 0;
    for (int r = 0; r < `ROB_PHYS_REGS; r++) begin
      ready_model[r] = 1'b1;
    end
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    // mixed traffic with mispredict flushes
    repeat (600) run_cycle(1'b1, 1'b1);
    // fill with no writebacks
    guard = 0;
    while (model_q.size() <= `ROB_ENTRIES - W && guard < 100) begin
      run_cycle(1'b1, 1'b0);
      guard++;
    end
    if (model_q.size() <= `ROB_ENTRIES - W) fail_timeout("the ROB did not fill in time");
    run_cycle(1'b0, 1'b0);
    // drain
    guard = 0;
    while (model_q.size() != 0 && guard < 300) begin
      run_cycle(1'b0, 1'b1);
      guard++;
    end
    if (model_q.size() != 0) fail_timeout("the ROB did not drain in time");
    run_cycle(1'b0, 1'b0);
    check_value("full_after_drain", 0, dispatch_full);
    check_value("flush_seen", 1, flush_count > 0);
    if (dut0.asserts0.fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// File: tb.f
+incdir+.
rob_pkg.sv
rob_alloc.sv
rob_bank.sv
rob_retire.sv
rob_ready_table.sv
rob_top.sv
rob_asserts.sv
tb_rob.sv

// File: Bender.yml
package:
  name: rob

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rob_pkg.sv
      - rob_alloc.sv
      - rob_bank.sv
      - rob_retire.sv
      - rob_ready_table.sv
      - rob_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rob_asserts.sv
      - tb_rob.sv
